/* hw/cacheControl.sv */
`timescale 1ns/1ns

module cacheControl (
    input logic CLK,
    input logic nRST,
    input cachePkg::cpuReq_t cpuReq,
    input logic hit,
    input logic hitWay,
    input logic victimWay,
    input logic victimDirty,
    input cachePkg::tag_t victimTag,
    input cachePkg::word_t victimWord,
    input cachePkg::memResp_t memResp,
    output logic cpuHit,
    output logic touch,
    output logic markDirty,
    output logic fill,
    output logic fillWay,
    output logic wordWrite,
    output logic wordWay,
    output logic wordSel,
    output logic wordSrcMem,
    output cachePkg::memReq_t memReq
);
    import cachePkg::*;

    ctrlState_t state;
    ctrlState_t nextState;

    logic missWay;      // victim way, held for the whole miss
    logic request;
    logic miss;
    logic wordBit;      // word of the block in the current memory transfer
    logic inCompare;
    index_t reqIndex;

    assign request = cpuReq.ren || cpuReq.wen;
    assign inCompare = (state == compareTag);
    assign miss = inCompare && request && !hit;
    assign reqIndex = cpuReq.addr[5:3];
    assign wordBit = (state == writeBack1) || (state == allocate1);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= compareTag;
            missWay <= 1'b0;
        end else begin
            state <= nextState;
            if (miss) begin
                missWay <= victimWay;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            compareTag: begin
                if (miss) begin
                    nextState = victimDirty ? writeBack0 : allocate0;
                end
            end
            writeBack0: begin
                if (!memResp.busy) nextState = writeBack1;
            end
            writeBack1: begin
                if (!memResp.busy) nextState = allocate0;
            end
            allocate0: begin
                if (!memResp.busy) nextState = allocate1;
            end
            allocate1: begin
                // block is valid after this edge, the next compare hits
                if (!memResp.busy) nextState = compareTag;
            end
            default: nextState = compareTag;
        endcase
    end

    // word write routing, processor store on a hit, memory load on a fill
    assign wordWay = inCompare ? hitWay : missWay;
    assign wordSel = inCompare ? cpuReq.addr[2] : wordBit;  // also picks the write-back word
    assign wordSrcMem = !inCompare;
    assign fillWay = missWay;

    always_comb begin
        cpuHit = 1'b0;
        touch = 1'b0;
        markDirty = 1'b0;
        wordWrite = 1'b0;
        fill = 1'b0;
        case (state)
            compareTag: begin
                if (request && hit) begin
                    cpuHit = 1'b1;
                    touch = 1'b1;
                    if (cpuReq.wen) begin
                        // store merge, also for a write miss after its fill
                        markDirty = 1'b1;
                        wordWrite = 1'b1;
                    end
                end
            end
            allocate0: begin
                wordWrite = !memResp.busy;
            end
            allocate1: begin
                wordWrite = !memResp.busy;
                fill = !memResp.busy;
            end
            default: begin
                wordWrite = 1'b0;
            end
        endcase
    end

    always_comb begin
        memReq = '0;
        case (state)
            writeBack0, writeBack1: begin
                memReq.wen = 1'b1;
                memReq.addr = {victimTag, reqIndex, wordBit, 2'b00};  // old block address
                memReq.store = victimWord;
            end
            allocate0, allocate1: begin
                memReq.ren = 1'b1;
                memReq.addr = {cpuReq.addr[31:3], wordBit, 2'b00};
            end
            default: begin
                memReq = '0;
            end
        endcase
    end

endmodule

/* hw/cachePkg.sv */
package cachePkg;

    // datapath widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // address split: tag | index | word | byte
    typedef logic [25:0] tag_t;   // addr[31:6]
    typedef logic [2:0] index_t;  // addr[5:3]

    // processor side
    typedef struct packed {
        logic ren;
        logic wen;
        addr_t addr;
        word_t store;
    } cpuReq_t;

    typedef struct packed {
        logic hit;      // one cycle per request
        word_t load;
    } cpuResp_t;

    // memory side, one word per transfer
    typedef struct packed {
        logic ren;
        logic wen;
        addr_t addr;
        word_t store;
    } memReq_t;

    typedef struct packed {
        logic busy;     // word done when low
        word_t load;
    } memResp_t;

    typedef enum logic [2:0] {
        compareTag,
        writeBack0,
        writeBack1,
        allocate0,
        allocate1
    } ctrlState_t;

endpackage

/* hw/dataArray.sv */
`timescale 1ns/1ns

module dataArray (
    input logic CLK,
    input logic nRST,
    input cachePkg::index_t reqIndex,
    input logic reqWordSel,
    input logic hitWay,
    input logic wordWrite,
    input logic wordWay,
    input logic wordSel,
    input logic wordSrcMem,
    input cachePkg::word_t cpuStore,
    input cachePkg::word_t memLoad,
    output cachePkg::word_t loadWord,
    input logic victimWay,
    input logic victimWordSel,
    output cachePkg::word_t victimWord
);
    import cachePkg::*;

    localparam int numSets = 2 ** $bits(index_t);

    word_t words [numSets][2][2];   // set, way, word
    word_t writeData;

    assign writeData = wordSrcMem ? memLoad : cpuStore;

    // processor read from the hit way
    assign loadWord = words[reqIndex][hitWay][reqWordSel];
    // old block word for write-back
    assign victimWord = words[reqIndex][victimWay][victimWordSel];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            words <= '{default: '0};
        end else if (wordWrite) begin
            words[reqIndex][wordWay][wordSel] <= writeData;
        end
    end

endmodule

/* hw/dcacheTop.sv */
`timescale 1ns/1ns

module dcacheTop (
    input logic CLK,
    input logic nRST,
    input cachePkg::cpuReq_t cpuReq,
    output cachePkg::cpuResp_t cpuResp,
    output cachePkg::memReq_t memReq,
    input cachePkg::memResp_t memResp
);
    import cachePkg::*;

    tag_t reqTag;
    index_t reqIndex;
    logic reqWordSel;

    // tag array results
    logic hit;
    logic hitWay;
    logic victimWay;
    logic victimDirty;
    tag_t victimTag;
    word_t victimWord;

    // commands from control
    logic touch;
    logic markDirty;
    logic fill;
    logic fillWay;
    logic wordWrite;
    logic wordWay;
    logic wordSel;
    logic wordSrcMem;

    assign reqTag = cpuReq.addr[31:6];
    assign reqIndex = cpuReq.addr[5:3];
    assign reqWordSel = cpuReq.addr[2];

    cacheControl cacheControl_inst (
        .CLK(CLK),
        .nRST(nRST),
        .cpuReq(cpuReq),
        .hit(hit),
        .hitWay(hitWay),
        .victimWay(victimWay),
        .victimDirty(victimDirty),
        .victimTag(victimTag),
        .victimWord(victimWord),
        .memResp(memResp),
        .cpuHit(cpuResp.hit),
        .touch(touch),
        .markDirty(markDirty),
        .fill(fill),
        .fillWay(fillWay),
        .wordWrite(wordWrite),
        .wordWay(wordWay),
        .wordSel(wordSel),
        .wordSrcMem(wordSrcMem),
        .memReq(memReq)
    );

    tagArray tagArray_inst (
        .CLK(CLK),
        .nRST(nRST),
        .reqTag(reqTag),
        .reqIndex(reqIndex),
        .touch(touch),
        .markDirty(markDirty),
        .fill(fill),
        .fillWay(fillWay),
        .hit(hit),
        .hitWay(hitWay),
        .victimWay(victimWay),
        .victimDirty(victimDirty),
        .victimTag(victimTag)
    );

    dataArray dataArray_inst (
        .CLK(CLK),
        .nRST(nRST),
        .reqIndex(reqIndex),
        .reqWordSel(reqWordSel),
        .hitWay(hitWay),
        .wordWrite(wordWrite),
        .wordWay(wordWay),
        .wordSel(wordSel),
        .wordSrcMem(wordSrcMem),
        .cpuStore(cpuReq.store),
        .memLoad(memResp.load),
        .loadWord(cpuResp.load),
        .victimWay(victimWay),
        .victimWordSel(wordSel),    // write-back word follows the control word bit
        .victimWord(victimWord)
    );

endmodule

/* hw/tagArray.sv */
`timescale 1ns/1ns

module tagArray (
    input logic CLK,
    input logic nRST,
    input cachePkg::tag_t reqTag,
    input cachePkg::index_t reqIndex,
    input logic touch,
    input logic markDirty,
    input logic fill,
    input logic fillWay,
    output logic hit,
    output logic hitWay,
    output logic victimWay,
    output logic victimDirty,
    output cachePkg::tag_t victimTag
);
    import cachePkg::*;

    localparam int numSets = 2 ** $bits(index_t);

    tag_t tags [numSets][2];
    logic [1:0] valid [numSets];
    logic [1:0] dirty [numSets];
    logic [numSets-1:0] lru;    // way to replace next

    logic [1:0] wayHit;

    // lookup for the set of the current request
    assign wayHit[0] = valid[reqIndex][0] && (tags[reqIndex][0] == reqTag);
    assign wayHit[1] = valid[reqIndex][1] && (tags[reqIndex][1] == reqTag);
    assign hit = |wayHit;
    assign hitWay = wayHit[1];

    assign victimWay = lru[reqIndex];
    assign victimTag = tags[reqIndex][victimWay];
    assign victimDirty = valid[reqIndex][victimWay] && dirty[reqIndex][victimWay];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < numSets; s++) begin
                valid[s] <= 2'b00;
                dirty[s] <= 2'b00;
            end
            lru <= '0;
        end else if (fill) begin
            valid[reqIndex][fillWay] <= 1'b1;
            dirty[reqIndex][fillWay] <= 1'b0;
            lru[reqIndex] <= ~fillWay;
        end else begin
            if (touch) begin
                lru[reqIndex] <= ~hitWay;
            end
            if (markDirty) begin
                dirty[reqIndex][hitWay] <= 1'b1;
            end
        end
    end

    // new tag with the fill
    always_ff @(posedge CLK) begin
        if (fill) begin
            tags[reqIndex][fillWay] <= reqTag;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module dcacheTb -f verilog.f -o dcacheSim --Mdir obj_dir

./obj_dir/dcacheSim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* tests/clockGen.sv */
`timescale 1ns/1ns

module clockGen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;  // 8 ns period
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        nRST = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

/* tests/dcacheTb.sv */
`timescale 1ns/1ns

module dcacheTb;
    import cachePkg::*;

    localparam int memWords = 1024;
    localparam int hitTimeout = 100;   // cycles per request

    logic CLK;
    logic nRST;
    cpuReq_t cpuReq;
    cpuResp_t cpuResp;
    memReq_t memReq;
    memResp_t memResp;
    addr_t peekAddr;
    word_t peekData;
    int readCount;
    int writeCount;

    word_t shadow [memWords];   // value a read must return
    int errorCount;
    int testCount;
    int failedTests;
    logic hung;

    clockGen clockGen_inst (
        .CLK(CLK),
        .nRST(nRST)
    );

    memModel memModel_inst (
        .CLK(CLK),
        .nRST(nRST),
        .memReq(memReq),
        .memResp(memResp),
        .peekAddr(peekAddr),
        .peekData(peekData),
        .readCount(readCount),
        .writeCount(writeCount)
    );

    dcacheTop dcacheTop_inst (
        .CLK(CLK),
        .nRST(nRST),
        .cpuReq(cpuReq),
        .cpuResp(cpuResp),
        .memReq(memReq),
        .memResp(memResp)
    );

    function automatic word_t patternWord(addr_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h0bad_0000;
    endfunction

    function automatic addr_t blockAddr(int tag, int index, int word);
        return {tag_t'(tag), index_t'(index), word[0], 2'b00};
    endfunction

    task automatic checkValue(string testName, word_t expected, word_t actual);
        if (!hung && expected !== actual) begin
            $display("ERR %s: expected %h, actual %h", testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic finishTest(string testName, int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s: ok", testName);
        end else begin
            failedTests++;
            $display("%s: %0d errors", testName, errorCount - errorsBefore);
        end
    endtask

    // one processor request held until hit with outputs sampled mid low phase
    task automatic access(input logic isWrite, input addr_t addr, input word_t data,
                          output word_t load, output int cycles);
        cycles = 0;
        load = '0;
        if (!hung) begin
            @(negedge CLK);
            cpuReq.ren = !isWrite;
            cpuReq.wen = isWrite;
            cpuReq.addr = addr;
            cpuReq.store = data;
            #2;
            while (!cpuResp.hit && cycles < hitTimeout) begin
                @(negedge CLK);
                #2;
                cycles++;
            end
            if (cycles >= hitTimeout) begin
                $display("timeout: no hit within %0d cycles for address %h", hitTimeout, addr);
                errorCount++;
                hung = 1'b1;
            end else begin
                load = cpuResp.load;
            end
            @(negedge CLK);
            cpuReq = '0;
        end
    endtask

    task automatic writeWord(addr_t addr, word_t data);
        word_t load;
        int cycles;
        access(1'b1, addr, data, load, cycles);
        shadow[addr[11:2]] = data;
    endtask

    task automatic readCheck(string testName, addr_t addr);
        word_t load;
        int cycles;
        access(1'b0, addr, '0, load, cycles);
        checkValue(testName, shadow[addr[11:2]], load);
    endtask

    task automatic peekMem(addr_t addr, output word_t data);
        peekAddr = addr;
        #1;
        data = peekData;
    endtask

    task automatic readMissTest();
        int errorsBefore;
        int reads;
        int writes;
        int cycles;
        word_t load;
        addr_t addr;
        errorsBefore = errorCount;
        addr = blockAddr(1, 0, 0);
        // idle outputs after reset
        checkValue("readMiss idle", 32'd0, {29'd0, cpuResp.hit, memReq.ren, memReq.wen});
        reads = readCount;
        writes = writeCount;
        access(1'b0, addr, '0, load, cycles);
        checkValue("readMiss", shadow[addr[11:2]], load);
        checkValue("readMiss reads", 32'd2, readCount - reads);
        checkValue("readMiss writes", 32'd0, writeCount - writes);
        finishTest("readMiss", errorsBefore);
    endtask

    task automatic readHitTest();
        int errorsBefore;
        int reads;
        int writes;
        int cycles;
        word_t load;
        addr_t addr;
        errorsBefore = errorCount;
        addr = blockAddr(1, 0, 1);   // other word of the block just filled
        reads = readCount;
        writes = writeCount;
        access(1'b0, addr, '0, load, cycles);
        checkValue("readHit", shadow[addr[11:2]], load);
        checkValue("readHit latency", 32'd0, cycles);
        checkValue("readHit reads", 32'd0, readCount - reads);
        checkValue("readHit writes", 32'd0, writeCount - writes);
        finishTest("readHit", errorsBefore);
    endtask

    task automatic writeHitTest();
        int errorsBefore;
        int reads;
        int writes;
        int cycles;
        word_t load;
        addr_t addr;
        errorsBefore = errorCount;
        addr = blockAddr(1, 0, 1);
        reads = readCount;
        writes = writeCount;
        access(1'b1, addr, 32'hcafe_0001, load, cycles);
        shadow[addr[11:2]] = 32'hcafe_0001;
        checkValue("writeHit latency", 32'd0, cycles);
        readCheck("writeHit readback", addr);
        checkValue("writeHit reads", 32'd0, readCount - reads);
        checkValue("writeHit writes", 32'd0, writeCount - writes);
        finishTest("writeHit", errorsBefore);
    endtask

    task automatic lruEvictTest();
        int errorsBefore;
        int reads;
        int writes;
        word_t memWord;
        addr_t a0;
        addr_t a1;
        errorsBefore = errorCount;
        a0 = blockAddr(2, 2, 0);
        a1 = blockAddr(2, 2, 1);
        writeWord(a0, 32'h1111_2222);
        writeWord(a1, 32'h3333_4444);
        writeWord(blockAddr(3, 2, 1), 32'h5555_6666);   // other way so tag 2 is now LRU
        reads = readCount;
        writes = writeCount;
        writeWord(blockAddr(4, 2, 0), 32'h7777_8888);
        checkValue("lruEvict writes", 32'd2, writeCount - writes);
        checkValue("lruEvict reads", 32'd2, readCount - reads);
        peekMem(a0, memWord);
        checkValue("lruEvict memory word 0", shadow[a0[11:2]], memWord);
        peekMem(a1, memWord);
        checkValue("lruEvict memory word 1", shadow[a1[11:2]], memWord);
        readCheck("lruEvict reread word 0", a0);
        readCheck("lruEvict reread word 1", a1);
        finishTest("lruEvict", errorsBefore);
    endtask

    task automatic writeMissTest();
        int errorsBefore;
        int reads;
        int writes;
        errorsBefore = errorCount;
        reads = readCount;
        writes = writeCount;
        writeWord(blockAddr(7, 5, 1), 32'hbeef_0005);
        checkValue("writeMiss reads", 32'd2, readCount - reads);
        checkValue("writeMiss writes", 32'd0, writeCount - writes);
        readCheck("writeMiss stored word", blockAddr(7, 5, 1));
        readCheck("writeMiss other word", blockAddr(7, 5, 0));
        finishTest("writeMiss", errorsBefore);
    endtask

    task automatic randomMixTest();
        int errorsBefore;
        addr_t addr;
        errorsBefore = errorCount;
        for (int i = 0; i < 200; i++) begin
            addr = blockAddr(10 + $urandom_range(5, 0), 4 + $urandom_range(3, 0),
                             $urandom_range(1, 0));
            if ($urandom_range(1, 0) == 1) writeWord(addr, $urandom());
            else readCheck("randomMix", addr);
        end
        // final sweep of every touched word
        for (int t = 10; t < 16; t++) begin
            for (int s = 4; s < 8; s++) begin
                readCheck("randomMix sweep", blockAddr(t, s, 0));
                readCheck("randomMix sweep", blockAddr(t, s, 1));
            end
        end
        finishTest("randomMix", errorsBefore);
    endtask

    initial begin
        int waited;
        cpuReq = '0;
        peekAddr = '0;
        errorCount = 0;
        testCount = 0;
        failedTests = 0;
        hung = 1'b0;
        void'($urandom(32'hd902));
        for (int i = 0; i < memWords; i++) begin
            shadow[i] = patternWord(addr_t'(i) << 2);
        end
        waited = 0;
        while (!nRST && waited < 100) begin
            @(negedge CLK);
            waited++;
        end
        if (!nRST) begin
            $display("reset was never released");
            errorCount++;
            hung = 1'b1;
        end
        readMissTest();
        readHitTest();
        writeHitTest();
        lruEvictTest();
        writeMissTest();
        randomMixTest();
        $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0 && !hung) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* tests/memModel.sv */
`timescale 1ns/1ns

module memModel (
    input logic CLK,
    input logic nRST,
    input cachePkg::memReq_t memReq,
    output cachePkg::memResp_t memResp,
    input cachePkg::addr_t peekAddr,
    output cachePkg::word_t peekData,
    output int readCount,
    output int writeCount
);
    import cachePkg::*;

    localparam int depth = 1024;   // 4 KB window, addr[11:2]

    word_t mem [depth];
    int waitLeft;       // wait cycles before the current word is done
    logic [9:0] wordIndex;
    logic active;
    logic done;

    function automatic word_t initWord(addr_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h0bad_0000;
    endfunction

    assign wordIndex = memReq.addr[11:2];
    assign active = memReq.ren || memReq.wen;
    assign done = active && (waitLeft == 0);

    assign memResp.busy = !done;
    assign memResp.load = memReq.ren ? mem[wordIndex] : '0;
    assign peekData = mem[peekAddr[11:2]];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = initWord({20'd0, i[9:0], 2'b00});
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            waitLeft <= 0;
            readCount <= 0;
            writeCount <= 0;
        end else if (active) begin
            if (waitLeft != 0) begin
                waitLeft <= waitLeft - 1;
            end else begin
                waitLeft <= $urandom_range(3, 0);  // next word
                if (memReq.wen) writeCount <= writeCount + 1;
                else readCount <= readCount + 1;
            end
        end
    end

    always @(posedge CLK) begin
        if (nRST && done && memReq.wen) begin
            mem[wordIndex] <= memReq.store;
        end
    end

endmodule

/* verilog.f */
hw/cachePkg.sv
hw/tagArray.sv
hw/dataArray.sv
hw/cacheControl.sv
hw/dcacheTop.sv
tests/clockGen.sv
tests/memModel.sv
tests/dcacheTb.sv
